// ==== bp_reg_bank/bp_reg_bank.sv ====
`timescale 1ns/1ps

module bp_reg_bank
  import bp_pkg::*;
#(
  // Number of registers built in this bank.
  parameter int N_REG = 32
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_cg,

  input  logic            i_hdr_stb,
  input  logic            i_hdr_wr,
  input  logic            i_wr_stb,
  input  logic [BP_W-1:0] i_byte,

  output logic            o_rsp_stb,
  output logic [BP_W-1:0] o_rsp_data
);

  // Storage covers only the implemented indices.
  logic [BP_W-1:0] mem [N_REG];

  // Index latched from the header, used by the data phase.
  logic [REG_IDX_W-1:0] idx_q;
  logic in_range_q;

  // Reply register and its one-cycle strobe.
  logic rsp_stb_q;
  logic [BP_W-1:0] rsp_data_q;

  // Decoded header fields.
  logic [$clog2(N_REG)-1:0] hdr_addr;
  logic [$clog2(N_REG)-1:0] wr_addr;
  logic hdr_in_range;
  logic rd_req;

  // Header index truncated to the storage depth.
  assign hdr_addr = i_byte[$clog2(N_REG)-1:0];

  // Stored index for the pending write.
  assign wr_addr = idx_q[$clog2(N_REG)-1:0];

  // Compare the full 5-bit index, so aliases above N_REG are caught.
  assign hdr_in_range = int'(i_byte[REG_IDX_W-1:0]) < N_REG;

  // A read header produces a reply at once.
  assign rd_req = i_hdr_stb && !i_hdr_wr;

  // Control state.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      idx_q      <= '0;
      in_range_q <= 1'b0;
      rsp_stb_q  <= 1'b0;
    end else if (i_cg) begin
      // Every header, read or write, updates the latched index.
      if (i_hdr_stb) begin
        idx_q      <= i_byte[REG_IDX_W-1:0];
        in_range_q <= hdr_in_range;
      end
      // Reply pulses one cycle after the request strobe.
      rsp_stb_q <= rd_req || i_wr_stb;
    end
  end

  // Reply payload.
  always_ff @(posedge i_clk) begin
    if (i_cg) begin
      if (rd_req) begin
        // Read returns content addressed by the incoming header.
        rsp_data_q <= hdr_in_range ? mem[hdr_addr] : '0;
      end else if (i_wr_stb) begin
        // Write returns the content held before this edge.
        rsp_data_q <= in_range_q ? mem[wr_addr] : '0;
      end
    end
  end

  // Register storage.
  // Out-of-range writes are dropped here.
  always_ff @(posedge i_clk) begin
    if (i_cg && i_wr_stb && in_range_q) begin
      mem[wr_addr] <= i_byte;
    end
  end

  assign o_rsp_stb = rsp_stb_q;

  // Zero outside the strobe so the collector can OR banks together.
  assign o_rsp_data = rsp_stb_q ? rsp_data_q : '0;

endmodule

// ==== common/bp_pkg.sv ====
// Shared constants for the byte-pipe register endpoint.
package bp_pkg;

  // Width of one byte-pipe word.
  localparam int BP_W = 8;

  // Number of register banks behind the dispatcher.
  localparam int N_BANKS = 4;

  // Header layout {wr:1, bank:2, reg:5}.
  localparam int BANK_SEL_W = 2;
  localparam int REG_IDX_W = 5;
  localparam int HDR_WR_BIT = 7;

  // Implemented registers per bank.
  // Indices at or above these read as zero and drop writes.
  localparam int BANK_REGS [N_BANKS] = '{32, 32, 16, 8};

  // Reply queue capacity, also the in-flight limit.
  localparam int REPLY_DEPTH = 2;

endpackage

// ==== dv/bp_reg_assertions.sv ====
`timescale 1ns/1ps

module bp_reg_assertions
  import bp_pkg::*;
(
  input logic            i_clk,
  input logic            i_rst_n,
  input logic            i_cg,
  input logic [BP_W-1:0] i_bp_data,
  input logic            i_bp_valid,
  input logic            o_bp_ready,
  input logic [BP_W-1:0] o_bp_data,
  input logic            o_bp_valid,
  input logic            i_bp_ready,
  input logic            i_room,
  input logic            i_req_stb
);

  // Failed assertion count for the end-of-run summary.
  int unsigned fail_cnt = 0;

  // Expected phase, rebuilt from the input handshakes.
  logic wr_data_next_q;
  // Replies owed to the host, counted at the stream ports.
  int owed_q;

  logic in_move;
  logic out_move;
  logic owes_reply;

  assign in_move  = i_bp_valid && o_bp_ready && i_cg;
  assign out_move = o_bp_valid && i_bp_ready && i_cg;

  // Read headers and write data bytes each owe one reply.
  assign owes_reply = wr_data_next_q || !i_bp_data[HDR_WR_BIT];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_data_next_q <= 1'b0;
      owed_q         <= 0;
    end else begin
      if (in_move) begin
        wr_data_next_q <= !wr_data_next_q && i_bp_data[HDR_WR_BIT];
      end
      owed_q <= owed_q + int'(in_move && owes_reply) - int'(out_move);
    end
  end

  // Output stream is idle after every reset edge.
  a_valid_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_bp_valid)
    else begin
      $error("o_bp_valid is high after a reset edge");
      fail_cnt++;
    end

  // A stalled reply keeps its data.
  a_data_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_bp_valid && !i_bp_ready) |=> (o_bp_valid && $stable(o_bp_data)))
    else begin
      $error("o_bp_data changed while the reply was stalled");
      fail_cnt++;
    end

  // Reply-producing bytes wait while two replies are outstanding.
  a_ready_no_room: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (owed_q >= REPLY_DEPTH && owes_reply) |-> !o_bp_ready)
    else begin
      $error("o_bp_ready is high with two replies outstanding");
      fail_cnt++;
    end

  // No reply starts beyond the in-flight limit.
  a_no_req_no_room: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_room |-> !i_req_stb)
    else begin
      $error("a reply was requested with two replies outstanding");
      fail_cnt++;
    end

endmodule

// ==== dv/bp_tb.sv ====
`timescale 1ns/1ps

module bp_tb;
  import bp_pkg::*;

  // Per-wait limits in clock cycles.
  localparam int ACC_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int MAX_REGS = 1 << REG_IDX_W;

  logic            i_clk = 1'b0;
  logic            i_rst_n;
  logic            i_cg;
  logic [BP_W-1:0] i_bp_data;
  logic            i_bp_valid;
  logic            o_bp_ready;
  logic [BP_W-1:0] o_bp_data;
  logic            o_bp_valid;
  logic            i_bp_ready = 1'b0;

  // Reference register content.
  logic [BP_W-1:0] model [N_BANKS][MAX_REGS];
  // Expected replies in order along with a compare flag and the owning test.
  logic [BP_W-1:0] exp_data [$];
  bit              exp_chk [$];
  string           exp_name [$];

  // Output sink is always ready (0), random (1) or stalled (2).
  int ready_mode = 0;
  string test_name = "reset";
  int n_val_err = 0;
  int n_orphan_err = 0;
  int n_other_err = 0;
  int n_replies = 0;

  bp_reg_subsystem DUT (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cg       (i_cg),
    .i_bp_data  (i_bp_data),
    .i_bp_valid (i_bp_valid),
    .o_bp_ready (o_bp_ready),
    .o_bp_data  (o_bp_data),
    .o_bp_valid (o_bp_valid),
    .i_bp_ready (i_bp_ready)
  );

  bind bp_reg_subsystem bp_reg_assertions u_assert (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cg       (i_cg),
    .i_bp_data  (i_bp_data),
    .i_bp_valid (i_bp_valid),
    .o_bp_ready (o_bp_ready),
    .o_bp_data  (o_bp_data),
    .o_bp_valid (o_bp_valid),
    .i_bp_ready (i_bp_ready),
    .i_room     (room),
    .i_req_stb  (req_stb)
  );

  always #10 i_clk = ~i_clk;

  // Output side back-pressure.
  always @(posedge i_clk) begin
    case (ready_mode)
      0: i_bp_ready <= 1'b1;
      1: i_bp_ready <= ($urandom % 2) == 0;
      default: i_bp_ready <= 1'b0;
    endcase
  end

  // Scoreboard compares each reply byte as it is taken.
  always @(posedge i_clk) begin
    if (i_rst_n && i_cg && o_bp_valid && i_bp_ready) begin
      if (exp_data.size() == 0) begin
        $display("ERROR: reply 0x%02h arrived with no request outstanding", o_bp_data);
        n_orphan_err++;
      end else begin
        if (exp_chk[0] && o_bp_data !== exp_data[0]) begin
          $display("CHECK FAILED %s: expected 0x%02h, actual 0x%02h",
                   exp_name[0], exp_data[0], o_bp_data);
          n_val_err++;
        end
        void'(exp_data.pop_front());
        void'(exp_chk.pop_front());
        void'(exp_name.pop_front());
        n_replies++;
      end
    end
  end

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  // Offer one byte and wait until it moves.
  task automatic send_byte(input logic [BP_W-1:0] b);
    int waited;
    bit taken;
    waited = 0;
    taken = 1'b0;
    i_bp_data  <= b;
    i_bp_valid <= 1'b1;
    while (!taken && waited < ACC_TIMEOUT) begin
      @(posedge i_clk);
      taken = i_bp_valid && o_bp_ready && i_cg;
      waited++;
    end
    if (!taken) begin
      abort_run($sformatf("input byte 0x%02h was never accepted", b));
    end
  endtask

  task automatic idle(input int n);
    i_bp_valid <= 1'b0;
    repeat (n) @(posedge i_clk);
  endtask

  // Stop offering input and wait until every expected reply is taken.
  task automatic drain_replies();
    int waited;
    waited = 0;
    i_bp_valid <= 1'b0;
    while (exp_data.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
    end
    if (exp_data.size() != 0) begin
      abort_run($sformatf("%0d replies still missing after the drain", exp_data.size()));
    end
  endtask

  function automatic void expect_reply(input logic [BP_W-1:0] d, input bit chk);
    exp_data.push_back(d);
    exp_chk.push_back(chk);
    exp_name.push_back(test_name);
  endfunction

  // Unbuilt indices read as zero.
  function automatic logic [BP_W-1:0] model_read(input int bank, input int idx);
    if (idx < BANK_REGS[bank]) begin
      return model[bank][idx];
    end
    return '0;
  endfunction

  task automatic do_read(input int bank, input int idx);
    send_byte({1'b0, BANK_SEL_W'(bank), REG_IDX_W'(idx)});
    expect_reply(model_read(bank, idx), 1'b1);
  endtask

  // Reply carries the old content, then the model takes the new byte.
  task automatic do_write(input int bank, input int idx, input logic [BP_W-1:0] d,
                          input bit chk);
    send_byte({1'b1, BANK_SEL_W'(bank), REG_IDX_W'(idx)});
    send_byte(d);
    expect_reply(model_read(bank, idx), chk);
    if (idx < BANK_REGS[bank]) begin
      model[bank][idx] = d;
    end
  endtask

  task automatic rand_txn(input bit allow_wr);
    int bank;
    int idx;
    bank = int'($urandom % N_BANKS);
    idx = int'($urandom % MAX_REGS);
    if (allow_wr && ($urandom % 2) == 1) begin
      do_write(bank, idx, BP_W'($urandom), 1'b1);
    end else begin
      do_read(bank, idx);
    end
    // Occasional gaps on the input stream.
    if (($urandom % 4) == 0) begin
      idle(int'($urandom % 3) + 1);
    end
  endtask

  initial begin
    int bank;
    int idx;
    int n_assert;
    logic snap_valid;
    logic [BP_W-1:0] snap_data;
    void'($urandom(94));
    i_rst_n = 1'b0;
    i_cg = 1'b1;
    i_bp_data = '0;
    i_bp_valid = 1'b0;
    repeat (16) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(posedge i_clk);

    // Bank content is unreset, so first in-range replies are not compared.
    test_name = "init_writes";
    for (bank = 0; bank < N_BANKS; bank++) begin
      for (idx = 0; idx < MAX_REGS; idx++) begin
        do_write(bank, idx, BP_W'($urandom), idx >= BANK_REGS[bank]);
      end
    end

    test_name = "random_reads";
    repeat (200) rand_txn(1'b0);

    // Each write is followed by a read of the same index.
    test_name = "write_replies";
    repeat (40) begin
      bank = int'($urandom % N_BANKS);
      idx = int'($urandom % MAX_REGS);
      do_write(bank, idx, BP_W'($urandom), 1'b1);
      do_read(bank, idx);
    end

    test_name = "mixed_backpressure";
    ready_mode = 1;
    repeat (300) rand_txn(1'b1);

    // Empty the queue, park one reply, then close the gate with a header on offer.
    test_name = "clock_gate";
    ready_mode = 0;
    drain_replies();
    ready_mode = 2;
    do_read(0, 3);
    idle(4);
    ready_mode = 1;
    i_cg <= 1'b0;
    i_bp_valid <= 1'b1;
    i_bp_data <= {1'b0, BANK_SEL_W'(1), REG_IDX_W'(7)};
    @(posedge i_clk);
    snap_valid = o_bp_valid;
    snap_data = o_bp_data;
    if (!snap_valid) begin
      $display("ERROR: no reply was held when the clock gate closed");
      n_other_err++;
    end
    repeat (20) begin
      @(posedge i_clk);
      if (o_bp_valid !== snap_valid || o_bp_data !== snap_data) begin
        $display("ERROR: reply output changed while the clock gate was low");
        n_other_err++;
      end
    end
    i_cg <= 1'b1;
    do_read(1, 7);
    repeat (50) rand_txn(1'b1);

    // Drain the remaining replies.
    ready_mode = 0;
    drain_replies();
    idle(10);
    n_assert = int'(DUT.u_assert.fail_cnt);
    $display("errors: value %0d, orphan %0d, other %0d, assertion %0d (replies %0d)",
             n_val_err, n_orphan_err, n_other_err, n_assert, n_replies);
    if (n_val_err + n_orphan_err + n_other_err + n_assert == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register endpoint testbench with Verilator.

LOG=sim.log
BUILD_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module bp_tb -Mdir "$BUILD_DIR" -o bp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/bp_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
exit 0

// ==== src/bp_dispatch.sv ====
`timescale 1ns/1ps

module bp_dispatch
  import bp_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_cg,

  input  logic [BP_W-1:0]    i_bp_data,
  input  logic               i_bp_valid,
  output logic               o_bp_ready,

  input  logic               i_room,

  output logic [N_BANKS-1:0] o_hdr_stb,
  output logic               o_hdr_wr,
  output logic [N_BANKS-1:0] o_wr_stb,
  output logic [BP_W-1:0]    o_byte
);

  // Phase register, high while a write data byte is expected.
  logic data_phase_q;

  // Bank selected by the pending write header.
  logic [BANK_SEL_W-1:0] sel_q;

  // Header decode.
  logic [BANK_SEL_W-1:0] hdr_bank;
  logic hdr_is_wr;

  // A byte moves only when the clock gate is open.
  logic in_acc;
  logic hdr_acc;
  logic data_acc;

  assign hdr_bank  = i_bp_data[REG_IDX_W +: BANK_SEL_W];
  assign hdr_is_wr = i_bp_data[HDR_WR_BIT];

  // Write headers never produce a reply, so they skip the room check.
  // Read headers and data bytes each need one reply slot.
  assign o_bp_ready = i_room || (!data_phase_q && hdr_is_wr);

  assign in_acc   = i_bp_valid && o_bp_ready && i_cg;
  assign hdr_acc  = in_acc && !data_phase_q;
  assign data_acc = in_acc && data_phase_q;

  // One-hot strobes towards the banks.
  always_comb begin
    o_hdr_stb = '0;
    o_wr_stb  = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      o_hdr_stb[b] = hdr_acc && (int'(hdr_bank) == b);
      o_wr_stb[b]  = data_acc && (int'(sel_q) == b);
    end
  end

  // Header and data share one byte bus.
  assign o_hdr_wr = hdr_is_wr;
  assign o_byte   = i_bp_data;

  // Phase tracking.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      data_phase_q <= 1'b0;
      sel_q        <= '0;
    end else begin
      if (hdr_acc) begin
        // Only a write header waits for a data byte.
        data_phase_q <= hdr_is_wr;
        sel_q        <= hdr_bank;
      end else if (data_acc) begin
        data_phase_q <= 1'b0;
      end
    end
  end

endmodule

// ==== src/bp_reg_subsystem.sv ====
`timescale 1ns/1ps

module bp_reg_subsystem
  import bp_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_cg,

  input  logic [BP_W-1:0] i_bp_data,
  input  logic            i_bp_valid,
  output logic            o_bp_ready,

  output logic [BP_W-1:0] o_bp_data,
  output logic            o_bp_valid,
  input  logic            i_bp_ready
);

  // Dispatcher to banks.
  logic [N_BANKS-1:0] hdr_stb;
  logic hdr_wr;
  logic [N_BANKS-1:0] wr_stb;
  logic [BP_W-1:0] bus_byte;

  // Banks to collector.
  logic [N_BANKS-1:0] rsp_stb;
  logic [N_BANKS-1:0][BP_W-1:0] rsp_data;

  // Collector back to dispatcher.
  logic room;
  logic req_stb;

  // A reply is owed for read headers and for write data bytes.
  assign req_stb = ((|hdr_stb) && !hdr_wr) || (|wr_stb);

  bp_dispatch u_dispatch (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cg       (i_cg),
    .i_bp_data  (i_bp_data),
    .i_bp_valid (i_bp_valid),
    .o_bp_ready (o_bp_ready),
    .i_room     (room),
    .o_hdr_stb  (hdr_stb),
    .o_hdr_wr   (hdr_wr),
    .o_wr_stb   (wr_stb),
    .o_byte     (bus_byte)
  );

  // One bank per header bank code, sized from the package table.
  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    bp_reg_bank #(
      .N_REG (BANK_REGS[b])
    ) u_bank (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_cg       (i_cg),
      .i_hdr_stb  (hdr_stb[b]),
      .i_hdr_wr   (hdr_wr),
      .i_wr_stb   (wr_stb[b]),
      .i_byte     (bus_byte),
      .o_rsp_stb  (rsp_stb[b]),
      .o_rsp_data (rsp_data[b])
    );
  end

  bp_reply_collect u_collect (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cg       (i_cg),
    .i_rsp_stb  (rsp_stb),
    .i_rsp_data (rsp_data),
    .i_req_stb  (req_stb),
    .o_room     (room),
    .o_bp_data  (o_bp_data),
    .o_bp_valid (o_bp_valid),
    .i_bp_ready (i_bp_ready)
  );

endmodule

// ==== src/bp_reply_collect.sv ====
`timescale 1ns/1ps

module bp_reply_collect
  import bp_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_cg,

  input  logic [N_BANKS-1:0]           i_rsp_stb,
  input  logic [N_BANKS-1:0][BP_W-1:0] i_rsp_data,
  input  logic                         i_req_stb,

  output logic                         o_room,

  output logic [BP_W-1:0]              o_bp_data,
  output logic                         o_bp_valid,
  input  logic                         i_bp_ready
);

  // Reply FIFO, payload only.
  logic [BP_W-1:0] fifo_mem [REPLY_DEPTH];
  logic [$clog2(REPLY_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(REPLY_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(REPLY_DEPTH+1)-1:0] fill_q;

  // Replies in production plus entries held.
  logic [$clog2(REPLY_DEPTH+1)-1:0] out_cnt_q;

  logic [BP_W-1:0] merged_data;
  logic push;
  logic pop;

  // Banks zero their data outside the strobe, so OR is enough.
  always_comb begin
    merged_data = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      merged_data = merged_data | i_rsp_data[b];
    end
  end

  assign push = (|i_rsp_stb) && i_cg;
  assign pop  = o_bp_valid && i_bp_ready && i_cg;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      fill_q    <= '0;
      out_cnt_q <= '0;
    end else if (i_cg) begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Never overflows, the dispatcher stops at REPLY_DEPTH outstanding.
      fill_q    <= fill_q + push - pop;
      out_cnt_q <= out_cnt_q + i_req_stb - pop;
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= merged_data;
    end
  end

  assign o_room     = int'(out_cnt_q) < REPLY_DEPTH;
  assign o_bp_valid = (fill_q != '0);
  assign o_bp_data  = fifo_mem[rd_ptr_q];

endmodule

// ==== tb.f ====
common/bp_pkg.sv
bp_reg_bank/bp_reg_bank.sv
src/bp_dispatch.sv
src/bp_reply_collect.sv
src/bp_reg_subsystem.sv
dv/bp_reg_assertions.sv
dv/bp_tb.sv
